//--- rtl/merge_pkg.sv
`default_nettype none

package merge_pkg;

    // ------------------------------------------------------------------
    // Widths and depths
    // ------------------------------------------------------------------
    localparam int NUM_LANES   = 2;
    localparam int DATA_W      = 32;
    localparam int INDEX_W     = 8;
    localparam int COUNT_W     = 16;
    localparam int FIFO_DEPTH  = 16;
    localparam int PROG_THRESH = 12;

    // Index values of the configuration words on the memory stream
    localparam int CFG_IDX_OP   = 0;
    localparam int CFG_IDX_MASK = 1;

    // ------------------------------------------------------------------
    // Packets
    // ------------------------------------------------------------------
    typedef struct packed {
        logic [INDEX_W-1:0] index;
        logic [DATA_W-1:0]  data;
    } packet_payload_t;

    typedef struct packed {
        logic            valid;
        packet_payload_t payload;
    } memory_packet_t;

    // ------------------------------------------------------------------
    // Configuration and control
    // ------------------------------------------------------------------
    typedef enum logic [1:0] {
        OP_PASS = 2'd0,
        OP_ADD  = 2'd1,
        OP_MAX  = 2'd2,
        OP_XOR  = 2'd3
    } merge_op_e;

    typedef struct packed {
        merge_op_e            op;
        logic [NUM_LANES-1:0] lane_mask;
    } merge_config_t;

    typedef struct packed {
        logic               valid;
        logic [COUNT_W-1:0] count;
    } kernel_descriptor_t;

    // Generator run states
    typedef enum logic [1:0] {
        GEN_IDLE  = 2'd0,
        GEN_RUN   = 2'd1,
        GEN_DRAIN = 2'd2
    } gen_state_e;

endpackage : merge_pkg

`default_nettype wire

//--- rtl/sync_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module sync_fifo import merge_pkg::*; #(
    parameter int DEPTH = FIFO_DEPTH
) (
    input  logic            ap_clk,
    input  logic            areset_csr_engine,
    input  packet_payload_t din,
    input  logic            wr_en,
    input  logic            rd_en,
    output packet_payload_t dout,
    output logic            valid,
    output logic            empty,
    output logic            prog_full
);

    localparam int ADDR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W  = $clog2(DEPTH + 1);

    packet_payload_t   mem [DEPTH];
    logic [ADDR_W-1:0] wr_ptr;
    logic [ADDR_W-1:0] rd_ptr;
    logic [CNT_W-1:0]  count;
    logic              full;
    logic              do_wr;
    logic              do_rd;

    // ------------------------------------------------------------------
    // Flags
    // ------------------------------------------------------------------
    assign full      = (count == CNT_W'(DEPTH));
    assign empty     = (count == '0);
    assign valid     = ~empty;
    assign prog_full = (count >= CNT_W'(PROG_THRESH));

    // Read on empty is dropped, write on full only with a read alongside
    assign do_rd = rd_en & ~empty;
    assign do_wr = wr_en & (~full | do_rd);

    // Head of the queue is visible without a read
    assign dout = mem[rd_ptr];

    // ------------------------------------------------------------------
    // Pointers and occupancy
    // ------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == ADDR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == ADDR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage
    always_ff @(posedge ap_clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= din;
        end
    end

endmodule : sync_fifo

`default_nettype wire

//--- rtl/merge_config_capture.sv
`timescale 1ns/10ps
`default_nettype none

module merge_config_capture import merge_pkg::*; (
    input  logic            ap_clk,
    input  logic            areset_csr_engine,
    input  packet_payload_t mem_head,
    input  logic            mem_valid,
    input  logic            cfg_take,
    output logic            mem_pop,
    output merge_config_t   cfg,
    output logic            cfg_valid
);

    logic seen_op;
    logic seen_mask;
    logic is_op_word;
    logic is_mask_word;

    // ------------------------------------------------------------------
    // Word decode
    // ------------------------------------------------------------------
    assign is_op_word   = (mem_head.index == INDEX_W'(CFG_IDX_OP));
    assign is_mask_word = (mem_head.index == INDEX_W'(CFG_IDX_MASK));

    assign cfg_valid = seen_op & seen_mask;

    // Hold off the memory stream once a full set is waiting
    assign mem_pop = mem_valid & ~cfg_valid;

    // ------------------------------------------------------------------
    // Completion flags
    // ------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            seen_op   <= 1'b0;
            seen_mask <= 1'b0;
        end else if (cfg_take) begin
            seen_op   <= 1'b0;
            seen_mask <= 1'b0;
        end else if (mem_pop) begin
            if (is_op_word) begin
                seen_op <= 1'b1;
            end
            if (is_mask_word) begin
                seen_mask <= 1'b1;
            end
        end
    end

    // A repeated word simply overwrites its field
    always_ff @(posedge ap_clk) begin
        if (mem_pop && is_op_word) begin
            cfg.op <= merge_op_e'(mem_head.data[1:0]);
        end
        if (mem_pop && is_mask_word) begin
            cfg.lane_mask <= mem_head.data[NUM_LANES-1:0];
        end
    end

endmodule : merge_config_capture

`default_nettype wire

//--- rtl/merge_generator.sv
`timescale 1ns/10ps
`default_nettype none

module merge_generator import merge_pkg::*; (
    input  logic                 ap_clk,
    input  logic                 areset_csr_engine,
    input  kernel_descriptor_t   descriptor,
    input  merge_config_t        cfg,
    input  logic                 cfg_valid,
    input  packet_payload_t      lane_head [NUM_LANES],
    input  logic [NUM_LANES-1:0] lane_valid,
    input  logic                 out_prog_full,
    output logic                 cfg_take,
    output logic [NUM_LANES-1:0] lane_pop,
    output memory_packet_t       result,
    output logic                 idle
);

    gen_state_e           state;
    logic [COUNT_W-1:0]   run_count;
    logic [COUNT_W-1:0]   step_cnt;
    merge_op_e            run_op;
    logic [NUM_LANES-1:0] run_mask;
    logic                 start;
    logic                 step_fire;
    logic                 last_step;

    // Stage one holds the popped lane words
    logic                 s1_valid;
    logic [INDEX_W-1:0]   s1_index;
    logic [DATA_W-1:0]    s1_data [NUM_LANES];
    logic [DATA_W-1:0]    merged;

    // ------------------------------------------------------------------
    // Run control
    // ------------------------------------------------------------------
    assign idle     = (state == GEN_IDLE);
    assign start    = idle & descriptor.valid & cfg_valid;
    assign cfg_take = start;

    // All enabled heads present and room left downstream
    assign step_fire = (state == GEN_RUN) & (&(lane_valid | ~run_mask)) & ~out_prog_full;
    assign lane_pop  = step_fire ? run_mask : '0;
    assign last_step = (step_cnt == run_count - 1'b1);

    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            state    <= GEN_IDLE;
            step_cnt <= '0;
            run_op   <= OP_PASS;
            run_mask <= NUM_LANES'(1);
        end else begin
            case (state)
                GEN_IDLE: begin
                    if (start) begin
                        step_cnt <= '0;
                        run_op   <= cfg.op;
                        // Empty mask falls back to lane 0
                        run_mask <= (cfg.lane_mask == '0) ? NUM_LANES'(1) : cfg.lane_mask;
                        state    <= (descriptor.count == '0) ? GEN_DRAIN : GEN_RUN;
                    end
                end
                GEN_RUN: begin
                    if (step_fire) begin
                        step_cnt <= step_cnt + 1'b1;
                        if (last_step) begin
                            state <= GEN_DRAIN;
                        end
                    end
                end
                GEN_DRAIN: begin
                    if (!s1_valid && !result.valid) begin
                        state <= GEN_IDLE;
                    end
                end
                default: state <= GEN_IDLE;
            endcase
        end
    end

    always_ff @(posedge ap_clk) begin
        if (start) begin
            run_count <= descriptor.count;
        end
    end

    // ------------------------------------------------------------------
    // Stage one: capture lane data and step index
    // ------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= step_fire;
        end
        if (step_fire) begin
            s1_index <= step_cnt[INDEX_W-1:0];
            for (int i = 0; i < NUM_LANES; i++) begin
                s1_data[i] <= lane_head[i].data;
            end
        end
    end

    // ------------------------------------------------------------------
    // Stage two: combine enabled lanes
    // ------------------------------------------------------------------
    always_comb begin : merge_lanes
        logic first;
        first  = 1'b1;
        merged = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            if (run_mask[i]) begin
                case (run_op)
                    OP_PASS: begin
                        if (first) begin
                            merged = s1_data[i];
                        end
                    end
                    OP_ADD:  merged = merged + s1_data[i];
                    // Unsigned compare
                    OP_MAX: begin
                        if (first || (s1_data[i] > merged)) begin
                            merged = s1_data[i];
                        end
                    end
                    default: merged = merged ^ s1_data[i];
                endcase
                first = 1'b0;
            end
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            result.valid <= 1'b0;
        end else begin
            result.valid <= s1_valid;
        end
        if (s1_valid) begin
            result.payload <= '{index: s1_index, data: merged};
        end
    end

endmodule : merge_generator

`default_nettype wire

//--- rtl/engine_merge_data.sv
`timescale 1ns/10ps
`default_nettype none

module engine_merge_data import merge_pkg::*; (
    input  logic                 ap_clk,
    input  logic                 areset_csr_engine,
    input  kernel_descriptor_t   descriptor_in,
    input  memory_packet_t       response_engine_in [NUM_LANES],
    input  memory_packet_t       response_memory_in,
    input  logic                 ready,
    output logic [NUM_LANES-1:0] response_engine_prog_full,
    output logic                 response_memory_prog_full,
    output memory_packet_t       request_engine_out,
    output logic                 done_out
);

    kernel_descriptor_t   descriptor_in_reg;
    memory_packet_t       response_engine_in_reg [NUM_LANES];
    memory_packet_t       response_memory_in_reg;

    // Lane FIFO heads
    packet_payload_t      lane_head [NUM_LANES];
    logic [NUM_LANES-1:0] lane_valid;
    logic [NUM_LANES-1:0] lane_empty;
    logic [NUM_LANES-1:0] lane_pop;

    // Configuration path
    packet_payload_t      mem_head;
    logic                 mem_valid;
    logic                 mem_empty;
    logic                 mem_pop;
    merge_config_t        cfg;
    logic                 cfg_valid;
    logic                 cfg_take;

    // Result path
    memory_packet_t       gen_result;
    logic                 gen_idle;
    packet_payload_t      out_head;
    logic                 out_valid;
    logic                 out_empty;
    logic                 out_prog_full;
    logic                 out_pop;

    // ------------------------------------------------------------------
    // Input registers
    // ------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            descriptor_in_reg.valid      <= 1'b0;
            response_memory_in_reg.valid <= 1'b0;
        end else begin
            descriptor_in_reg.valid      <= descriptor_in.valid;
            response_memory_in_reg.valid <= response_memory_in.valid;
        end
        descriptor_in_reg.count        <= descriptor_in.count;
        response_memory_in_reg.payload <= response_memory_in.payload;
    end

    always_ff @(posedge ap_clk) begin
        for (int i = 0; i < NUM_LANES; i++) begin
            if (areset_csr_engine) begin
                response_engine_in_reg[i].valid <= 1'b0;
            end else begin
                response_engine_in_reg[i].valid <= response_engine_in[i].valid;
            end
            response_engine_in_reg[i].payload <= response_engine_in[i].payload;
        end
    end

    // ------------------------------------------------------------------
    // FIFOs
    // ------------------------------------------------------------------
    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        sync_fifo #(.DEPTH(FIFO_DEPTH)) u_lane_fifo (
            .ap_clk           (ap_clk),
            .areset_csr_engine(areset_csr_engine),
            .din              (response_engine_in_reg[i].payload),
            .wr_en            (response_engine_in_reg[i].valid),
            .rd_en            (lane_pop[i]),
            .dout             (lane_head[i]),
            .valid            (lane_valid[i]),
            .empty            (lane_empty[i]),
            .prog_full        (response_engine_prog_full[i])
        );
    end

    sync_fifo #(.DEPTH(FIFO_DEPTH)) u_memory_fifo (
        .ap_clk           (ap_clk),
        .areset_csr_engine(areset_csr_engine),
        .din              (response_memory_in_reg.payload),
        .wr_en            (response_memory_in_reg.valid),
        .rd_en            (mem_pop),
        .dout             (mem_head),
        .valid            (mem_valid),
        .empty            (mem_empty),
        .prog_full        (response_memory_prog_full)
    );

    // Output pops on a completed handshake
    assign out_pop = ready & out_valid;

    sync_fifo #(.DEPTH(FIFO_DEPTH)) u_request_fifo (
        .ap_clk           (ap_clk),
        .areset_csr_engine(areset_csr_engine),
        .din              (gen_result.payload),
        .wr_en            (gen_result.valid),
        .rd_en            (out_pop),
        .dout             (out_head),
        .valid            (out_valid),
        .empty            (out_empty),
        .prog_full        (out_prog_full)
    );

    assign request_engine_out = '{valid: out_valid, payload: out_head};

    // ------------------------------------------------------------------
    // Configuration and merge
    // ------------------------------------------------------------------
    merge_config_capture u_config (
        .ap_clk           (ap_clk),
        .areset_csr_engine(areset_csr_engine),
        .mem_head         (mem_head),
        .mem_valid        (mem_valid),
        .cfg_take         (cfg_take),
        .mem_pop          (mem_pop),
        .cfg              (cfg),
        .cfg_valid        (cfg_valid)
    );

    merge_generator u_generator (
        .ap_clk           (ap_clk),
        .areset_csr_engine(areset_csr_engine),
        .descriptor       (descriptor_in_reg),
        .cfg              (cfg),
        .cfg_valid        (cfg_valid),
        .lane_head        (lane_head),
        .lane_valid       (lane_valid),
        .out_prog_full    (out_prog_full),
        .cfg_take         (cfg_take),
        .lane_pop         (lane_pop),
        .result           (gen_result),
        .idle             (gen_idle)
    );

    // Done once the generator is idle and nothing is left queued
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            done_out <= 1'b1;
        end else begin
            done_out <= gen_idle & (&lane_empty) & mem_empty & out_empty;
        end
    end

endmodule : engine_merge_data

`default_nettype wire

//--- bench/engine_merge_data_chk.sv
`timescale 1ns/10ps
`default_nettype none

module engine_merge_data_chk import merge_pkg::*; (
    input logic                 ap_clk,
    input logic                 areset_csr_engine,
    input memory_packet_t       response_engine_in [NUM_LANES],
    input logic [NUM_LANES-1:0] response_engine_prog_full,
    input memory_packet_t       response_memory_in,
    input logic                 response_memory_prog_full,
    input memory_packet_t       request_engine_out,
    input logic                 ready,
    input logic                 done_out
);

    // Number of assertion failures so far
    int failures = 0;

    // ------------------------------------------------------------------
    // Producers see the prog_full flag one edge late
    // ------------------------------------------------------------------
    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane_push
        lane_push_ok: assert property (@(posedge ap_clk) disable iff (areset_csr_engine)
            response_engine_in[i].valid |-> !$past(response_engine_prog_full[i]))
            else begin
                $error("lane %0d pushed while its prog_full was high", i);
                failures++;
            end
    end

    memory_push_ok: assert property (@(posedge ap_clk) disable iff (areset_csr_engine)
        response_memory_in.valid |-> !$past(response_memory_prog_full))
        else begin
            $error("memory stream pushed while its prog_full was high");
            failures++;
        end

    // Output head holds until taken
    output_stable: assert property (@(posedge ap_clk) disable iff (areset_csr_engine)
        (request_engine_out.valid && !ready) |=> $stable(request_engine_out))
        else begin
            $error("request_engine_out changed while stalled");
            failures++;
        end

    done_after_reset: assert property (@(posedge ap_clk)
        areset_csr_engine |=> done_out)
        else begin
            $error("done_out low right after reset");
            failures++;
        end

endmodule : engine_merge_data_chk

bind engine_merge_data engine_merge_data_chk chk0 (
    .ap_clk                   (ap_clk),
    .areset_csr_engine        (areset_csr_engine),
    .response_engine_in       (response_engine_in),
    .response_engine_prog_full(response_engine_prog_full),
    .response_memory_in       (response_memory_in),
    .response_memory_prog_full(response_memory_prog_full),
    .request_engine_out       (request_engine_out),
    .ready                    (ready),
    .done_out                 (done_out)
);

`default_nettype wire

//--- bench/tb_engine_merge_data.sv
`timescale 1ns/10ps
`default_nettype none

module tb_engine_merge_data import merge_pkg::*; ();

    localparam int MAX_STEPS    = 40;
    localparam int WAIT_LIMIT   = 4000;
    localparam int STALL_CYCLES = 120;
    localparam int NUM_RUNS     = 16;

    logic                 ap_clk;
    logic                 areset_csr_engine;
    kernel_descriptor_t   descriptor_in;
    memory_packet_t       response_engine_in [NUM_LANES];
    memory_packet_t       response_memory_in;
    logic                 ready;
    logic [NUM_LANES-1:0] response_engine_prog_full;
    logic                 response_memory_prog_full;
    memory_packet_t       request_engine_out;
    logic                 done_out;

    integer               seed = 32642;
    logic [DATA_W-1:0]    lane_data [NUM_LANES][MAX_STEPS];
    packet_payload_t      expected_q [$];
    logic                 run_active;
    logic [NUM_LANES-1:0] pf_seen;

    engine_merge_data dut0 (
        .ap_clk                   (ap_clk),
        .areset_csr_engine        (areset_csr_engine),
        .descriptor_in            (descriptor_in),
        .response_engine_in       (response_engine_in),
        .response_memory_in       (response_memory_in),
        .ready                    (ready),
        .response_engine_prog_full(response_engine_prog_full),
        .response_memory_prog_full(response_memory_prog_full),
        .request_engine_out       (request_engine_out),
        .done_out                 (done_out)
    );

    initial begin
        ap_clk = 1'b0;
    end

    always #50 ap_clk = ~ap_clk;

    // ------------------------------------------------------------------
    // Reporting
    // ------------------------------------------------------------------
    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("ERR %0t: %s, got 0x%0h, expected 0x%0h", $time, what, actual, expected);
            $display("** FAIL **");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic stop_on_timeout(input string why);
        $display("Timeout at %0t: %s", $time, why);
        $display("** FAIL **");
        $fatal(1, "stopped on timeout");
    endtask

    always @(posedge ap_clk) begin
        if (dut0.chk0.failures != 0) begin
            $display("** FAIL **");
            $fatal(1, "a checker assertion failed");
        end
    end

    // ------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------
    function automatic logic [DATA_W-1:0] expected_merge(input merge_op_e op,
            input logic [NUM_LANES-1:0] mask, input int step);
        logic [DATA_W-1:0] vals [$];
        logic [DATA_W-1:0] acc;
        for (int l = 0; l < NUM_LANES; l++) begin
            if (mask[l]) begin
                vals.push_back(lane_data[l][step]);
            end
        end
        // Pass keeps the lowest enabled lane
        acc = vals[0];
        for (int k = 1; k < vals.size(); k++) begin
            case (op)
                OP_ADD:  acc = acc + vals[k];
                OP_MAX:  acc = (vals[k] > acc) ? vals[k] : acc;
                OP_XOR:  acc = acc ^ vals[k];
                default: acc = acc;
            endcase
        end
        return acc;
    endfunction

    // ------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------
    task automatic push_memory_word(input int index, input logic [1:0] field);
        logic [DATA_W-1:0] word;
        int                waited;
        word      = DATA_W'($random(seed));
        word[1:0] = field;
        waited    = 0;
        @(posedge ap_clk);
        while (response_memory_prog_full) begin
            response_memory_in.valid <= 1'b0;
            waited++;
            if (waited > WAIT_LIMIT) begin
                stop_on_timeout("memory FIFO stayed full while sending configuration");
            end
            @(posedge ap_clk);
        end
        response_memory_in <= '{valid: 1'b1, payload: '{index: INDEX_W'(index), data: word}};
    endtask

    task automatic send_config(input merge_op_e op, input logic [NUM_LANES-1:0] mask);
        logic [1:0] field [2];
        int         first;
        int         waited;
        field[CFG_IDX_OP]   = op;
        field[CFG_IDX_MASK] = mask;
        first = $random(seed) & 1;
        // An earlier differing word of the same index gets overwritten
        if ($random(seed) & 1) begin
            push_memory_word(first, field[first] ^ 2'b11);
        end
        push_memory_word(first, field[first]);
        push_memory_word(1 - first, field[1 - first]);
        @(posedge ap_clk);
        response_memory_in.valid <= 1'b0;

        // done_out dips while the words sit in the memory FIFO
        waited = 0;
        while (done_out) begin
            @(posedge ap_clk);
            waited++;
            if (waited > 20) begin
                stop_on_timeout("done_out did not drop while configuration was queued");
            end
        end
        waited = 0;
        while (!done_out) begin
            @(posedge ap_clk);
            waited++;
            if (waited > 20) begin
                stop_on_timeout("configuration words were not consumed");
            end
        end
    endtask

    task automatic start_run(input int count);
        @(posedge ap_clk);
        descriptor_in <= '{valid: 1'b1, count: COUNT_W'(count)};
        for (int c = 1; c <= 4; c++) begin
            @(posedge ap_clk);
            if (c == 1) begin
                descriptor_in.valid <= 1'b0;
            end
            check_value(done_out, (c < 4), $sformatf("done_out %0d cycles after start", c));
        end
    endtask

    task automatic drive_lane(input int lane, input logic enabled, input int count);
        int gap;
        int waited;
        if (enabled) begin
            for (int s = 0; s < count; s++) begin
                gap = $random(seed) & 3;
                repeat (gap) begin
                    @(posedge ap_clk);
                    response_engine_in[lane].valid <= 1'b0;
                end
                waited = 0;
                @(posedge ap_clk);
                while (response_engine_prog_full[lane]) begin
                    response_engine_in[lane].valid <= 1'b0;
                    waited++;
                    if (waited > WAIT_LIMIT) begin
                        stop_on_timeout($sformatf("lane %0d FIFO never drained", lane));
                    end
                    @(posedge ap_clk);
                end
                response_engine_in[lane] <= '{valid: 1'b1,
                    payload: '{index: INDEX_W'(s), data: lane_data[lane][s]}};
            end
            @(posedge ap_clk);
            response_engine_in[lane].valid <= 1'b0;
        end
    endtask

    task automatic drive_ready(input logic stall);
        if (stall) begin
            @(posedge ap_clk);
            ready <= 1'b0;
            repeat (STALL_CYCLES) @(posedge ap_clk);
        end
        while (run_active) begin
            @(posedge ap_clk);
            ready <= (($random(seed) & 3) != 0);
        end
    endtask

    // ------------------------------------------------------------------
    // Output monitor
    // ------------------------------------------------------------------
    task automatic collect_results(input int count);
        packet_payload_t exp;
        int              got;
        int              quiet;
        got   = 0;
        quiet = 0;
        while (got < count) begin
            @(posedge ap_clk);
            check_value(done_out, 1'b0, "done_out high with results outstanding");
            pf_seen = pf_seen | response_engine_prog_full;
            if (request_engine_out.valid && ready) begin
                exp = expected_q.pop_front();
                check_value(request_engine_out.payload.index, exp.index, "result index");
                check_value(request_engine_out.payload.data, exp.data,
                            $sformatf("result data at step %0d", got));
                got++;
                quiet = 0;
            end else begin
                quiet++;
                if (quiet > WAIT_LIMIT) begin
                    stop_on_timeout($sformatf("only %0d of %0d results arrived", got, count));
                end
            end
        end
        run_active = 1'b0;
    endtask

    task automatic wait_done_high();
        int waited;
        waited = 0;
        @(posedge ap_clk);
        ready <= 1'b1;
        while (!done_out) begin
            check_value(request_engine_out.valid, 1'b0, "extra result after the run");
            @(posedge ap_clk);
            waited++;
            if (waited > 50) begin
                stop_on_timeout("done_out did not rise after the last result");
            end
        end
        check_value(request_engine_out.valid, 1'b0, "extra result after done");
    endtask

    task automatic run_once(input merge_op_e op, input logic [NUM_LANES-1:0] mask,
                            input logic stall);
        logic [NUM_LANES-1:0] eff;
        int                   count;
        eff = (mask == '0) ? NUM_LANES'(1) : mask;
        // Long runs so the lanes back up behind a stalled output
        if (stall) begin
            count = 32 + ($unsigned($random(seed)) % 9);
        end else begin
            count = 1 + ($unsigned($random(seed)) % MAX_STEPS);
        end

        expected_q.delete();
        for (int s = 0; s < count; s++) begin
            for (int l = 0; l < NUM_LANES; l++) begin
                lane_data[l][s] = $random(seed);
            end
            expected_q.push_back('{index: INDEX_W'(s), data: expected_merge(op, eff, s)});
        end

        send_config(op, mask);
        start_run(count);
        pf_seen    = '0;
        run_active = 1'b1;
        fork
            drive_lane(0, eff[0], count);
            drive_lane(1, eff[1], count);
            drive_ready(stall);
            collect_results(count);
        join
        if (stall) begin
            check_value(|(pf_seen & eff), 1'b1, "lane prog_full under back-pressure");
        end
        wait_done_high();
    endtask

    // ------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------
    initial begin
        merge_op_e            op;
        logic [NUM_LANES-1:0] mask;
        areset_csr_engine  = 1'b1;
        descriptor_in      = '0;
        response_memory_in = '0;
        ready              = 1'b0;
        run_active         = 1'b0;
        pf_seen            = '0;
        for (int l = 0; l < NUM_LANES; l++) begin
            response_engine_in[l] = '0;
        end

        repeat (16) @(posedge ap_clk);
        areset_csr_engine <= 1'b0;
        ready             <= 1'b1;
        @(posedge ap_clk);
        check_value(done_out, 1'b1, "done_out after reset");
        check_value(request_engine_out.valid, 1'b0, "output valid after reset");
        check_value(response_engine_prog_full, '0, "lane prog_full after reset");
        check_value(response_memory_prog_full, 1'b0, "memory prog_full after reset");

        // Every op with masks 01, 10, 11, then a few random ones
        for (int r = 0; r < NUM_RUNS; r++) begin
            if (r < 12) begin
                op   = merge_op_e'(r % 4);
                mask = NUM_LANES'(r / 4 + 1);
            end else begin
                op   = merge_op_e'(2'($random(seed)));
                mask = NUM_LANES'($random(seed));
            end
            run_once(op, mask, (r % 5) == 2);
        end

        if (dut0.chk0.failures == 0) begin
            $display("** PASS **");
            $finish;
        end else begin
            $display("** FAIL **");
            $fatal(1, "checker assertions failed");
        end
    end

endmodule : tb_engine_merge_data

`default_nettype wire

//--- verilog.f
rtl/merge_pkg.sv
rtl/sync_fifo.sv
rtl/merge_config_capture.sv
rtl/merge_generator.sv
rtl/engine_merge_data.sv
bench/engine_merge_data_chk.sv
bench/tb_engine_merge_data.sv
